// File: Makefile
# Verilator build and run of the loader testbench

VERILATOR ?= verilator
TOP       ?= tb_loader_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the log
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TESTS PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/cd_sector_streamer.sv
`timescale 1ns/1ps

module cd_sector_streamer import loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cd_start,
	input  logic                   cd_wr,
	input  logic [host_data_w-1:0] ioctl_dout,
	output logic [7:0]             cd_byte,
	output logic                   cd_byte_wr,
	output logic                   cd_dm,
	output logic                   busy
);

	logic                   head_done;
	logic [cd_len_w-1:0]    byte_len;
	logic [cd_len_w-1:0]    byte_cnt;
	logic [host_data_w-1:0] dat;
	logic                   byte_sel;

	// Low byte goes out first
	assign cd_byte = byte_sel ? dat[15:8] : dat[7:0];

	always_ff @(posedge clk_sys) begin
		if (cd_wr && head_done && (byte_cnt < byte_len)) begin
			dat <= ioctl_dout;
		end
	end

	////////////////////////////////////////////////////////////
	// Header and byte sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			head_done  <= 1'b0;
			byte_len   <= '0;
			byte_cnt   <= '0;
			byte_sel   <= 1'b0;
			cd_dm      <= 1'b0;
			cd_byte_wr <= 1'b0;
			busy       <= 1'b0;
		end else if (cd_start) begin
			head_done  <= 1'b0;
			byte_len   <= '0;
			byte_cnt   <= '0;
			cd_byte_wr <= 1'b0;
			busy       <= 1'b0;
		end else begin
			if (cd_wr) begin
				if (!head_done) begin
					// Header word: mode bit on top, byte count below
					{cd_dm, byte_len} <= ioctl_dout;
					byte_cnt          <= '0;
					head_done         <= 1'b1;
				end else if (byte_cnt < byte_len) begin
					busy     <= 1'b1;
					byte_sel <= 1'b0;
				end
			end

			// High one cycle, low one cycle per byte
			if (busy) begin
				if (!cd_byte_wr) begin
					cd_byte_wr <= 1'b1;
				end else begin
					cd_byte_wr <= 1'b0;
					byte_sel   <= ~byte_sel;
					byte_cnt   <= byte_cnt + 1'b1;
					if (byte_sel || (byte_cnt >= byte_len - 1'b1)) begin
						busy <= 1'b0;
					end
				end
			end
		end
	end

	// Consumer sees a gap after every byte
	assert property (@(posedge clk_sys) disable iff (reset) cd_byte_wr |=> !cd_byte_wr)
		else $error("cd_byte_wr high on two consecutive cycles");

endmodule

// File: rtl/cheat_loader.sv
`timescale 1ns/1ps

module cheat_loader import loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   code_wr,
	input  logic [3:0]             word_off,
	input  logic [host_data_w-1:0] ioctl_dout,
	output cheat_code_t            gg_code,
	output logic                   gg_code_valid
);

	logic [2:0] slot_sel;

	// Low half of a field sits one slot below its high half,
	// and fields run from the top slot pair downwards
	assign slot_sel = {~word_off[3:2], word_off[1]};

	always_ff @(posedge clk_sys) begin
		if (code_wr && !word_off[0]) begin
			gg_code.slots[slot_sel] <= ioctl_dout;
		end
	end

	// One pulse once the replace high word is in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_code_valid <= 1'b0;
		end else begin
			gg_code_valid <= code_wr && (word_off == cheat_last_off);
		end
	end

endmodule

// File: rtl/download_ctrl.sv
`timescale 1ns/1ps

module download_ctrl import loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_download,
	input  logic [host_idx_w-1:0] ioctl_index,
	input  logic                  ioctl_wr,
	input  logic                  word_done,
	input  logic                  busy,
	output logic                  cart_start,
	output logic                  cart_wr,
	output logic                  code_wr,
	output logic                  cd_start,
	output logic                  cd_wr,
	output logic                  ioctl_wait
);

	logic is_cart;
	logic is_cd;
	logic is_cheat;
	logic cart_dl;
	logic cd_dl;
	logic cheat_dl;
	logic cart_dl_q;
	logic cd_dl_q;
	logic cart_wait;

	// Index classes
	assign is_cart  = (ioctl_index <= idx_cart_max);
	assign is_cd    = (ioctl_index == idx_cd_data);
	assign is_cheat = (ioctl_index == idx_cheat);

	assign cart_dl  = ioctl_download & is_cart;
	assign cd_dl    = ioctl_download & is_cd;
	assign cheat_dl = ioctl_download & is_cheat;

	// Per-target write strobes, same cycle as the host strobe
	assign cart_wr = ioctl_wr & cart_dl;
	assign code_wr = ioctl_wr & cheat_dl;
	assign cd_wr   = ioctl_wr & cd_dl;

	// Start of a download, one cycle after the level rises
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q  <= 1'b0;
			cd_dl_q    <= 1'b0;
			cart_start <= 1'b0;
			cd_start   <= 1'b0;
		end else begin
			cart_dl_q  <= cart_dl;
			cd_dl_q    <= cd_dl;
			cart_start <= cart_dl & ~cart_dl_q;
			cd_start   <= cd_dl & ~cd_dl_q;
		end
	end

	// Held from a cartridge write until memory has taken the word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_wait <= 1'b0;
		end else if (cart_wr) begin
			cart_wait <= 1'b1;
		end else if (word_done) begin
			cart_wait <= 1'b0;
		end
	end

	assign ioctl_wait = cart_wait | busy;

	// Host holds cartridge words back while the previous one is in flight
	assert property (@(posedge clk_sys) disable iff (reset) cart_wr |-> !ioctl_wait)
		else $error("cartridge write while ioctl_wait is high");

endmodule

// File: rtl/loader_pkg.sv
package loader_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////

	localparam int host_data_w = 16;
	localparam int host_addr_w = 25;
	localparam int host_idx_w  = 8;
	localparam int mem_addr_w  = 24;
	localparam int cd_len_w    = 15;

	////////////////////////////////////////////////////////////
	// Download indices
	////////////////////////////////////////////////////////////

	// Index 0 is a plain ROM, index 1 a SuperGrafx image
	localparam logic [host_idx_w-1:0] idx_cart_max = 8'd1;
	localparam logic [host_idx_w-1:0] idx_cd_data  = 8'd2;
	localparam logic [host_idx_w-1:0] idx_cheat    = 8'hff;

	////////////////////////////////////////////////////////////
	// Populous signature
	////////////////////////////////////////////////////////////

	// Block addresses without the low four bits
	localparam logic [mem_addr_w-5:0] pop_sig_base_a = 20'h212;
	localparam logic [mem_addr_w-5:0] pop_sig_base_b = 20'h1f2;

	// Offsets of the four words inside a block
	localparam logic [3:0] pop_sig_off0 = 4'd6;
	localparam logic [3:0] pop_sig_off1 = 4'd8;
	localparam logic [3:0] pop_sig_off2 = 4'd10;
	localparam logic [3:0] pop_sig_off3 = 4'd12;

	// Expected words as they reach memory
	localparam logic [host_data_w-1:0] pop_sig_word0 = 16'h4f50;
	localparam logic [host_data_w-1:0] pop_sig_word1 = 16'h5550;
	localparam logic [host_data_w-1:0] pop_sig_word2 = 16'h4f4c;
	localparam logic [host_data_w-1:0] pop_sig_word3 = 16'h5355;

	////////////////////////////////////////////////////////////
	// Cheat code
	////////////////////////////////////////////////////////////

	// Host offset of the last word of a code
	localparam logic [3:0] cheat_last_off = 4'd14;

	// Loaded as eight host words, read as four 32-bit fields.
	// Offsets 0..14 go to slots 6,7,4,5,2,3,0,1
	typedef union packed {
		logic [7:0][host_data_w-1:0] slots;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
	} cheat_code_t;

endpackage

// File: rtl/loader_top.sv
`timescale 1ns/1ps

module loader_top import loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,

	// Host download port
	input  logic                   ioctl_download,
	input  logic [host_idx_w-1:0]  ioctl_index,
	input  logic                   ioctl_wr,
	input  logic [host_addr_w-1:0] ioctl_addr,
	input  logic [host_data_w-1:0] ioctl_dout,
	output logic                   ioctl_wait,
	input  logic                   swap_en,

	// Cartridge memory
	output logic                   mem_wr_req,
	input  logic                   mem_wr_ack,
	output logic [mem_addr_w-1:0]  mem_wr_addr,
	output logic [host_data_w-1:0] mem_wr_data,
	output logic [1:0]             rom_populous,
	output logic                   rom_sgx,

	// Cheat code
	output cheat_code_t            gg_code,
	output logic                   gg_code_valid,

	// CD sector bytes
	output logic [7:0]             cd_byte,
	output logic                   cd_byte_wr,
	output logic                   cd_dm
);

	logic cart_start;
	logic cart_wr;
	logic code_wr;
	logic cd_start;
	logic cd_wr;
	logic word_done;
	logic cd_busy;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	download_ctrl u_download_ctrl (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.word_done      (word_done),
		.busy           (cd_busy),
		.cart_start     (cart_start),
		.cart_wr        (cart_wr),
		.code_wr        (code_wr),
		.cd_start       (cd_start),
		.cd_wr          (cd_wr),
		.ioctl_wait     (ioctl_wait)
	);

	////////////////////////////////////////////////////////////
	// Datapaths
	////////////////////////////////////////////////////////////

	rom_writer u_rom_writer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_start   (cart_start),
		.cart_wr      (cart_wr),
		.sgx_sel      (ioctl_index[0]),
		.ioctl_dout   (ioctl_dout),
		.swap_en      (swap_en),
		.mem_wr_ack   (mem_wr_ack),
		.mem_wr_req   (mem_wr_req),
		.mem_wr_addr  (mem_wr_addr),
		.mem_wr_data  (mem_wr_data),
		.word_done    (word_done),
		.rom_populous (rom_populous),
		.rom_sgx      (rom_sgx)
	);

	cheat_loader u_cheat_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_wr       (code_wr),
		.word_off      (ioctl_addr[3:0]),
		.ioctl_dout    (ioctl_dout),
		.gg_code       (gg_code),
		.gg_code_valid (gg_code_valid)
	);

	cd_sector_streamer u_cd_sector_streamer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cd_start   (cd_start),
		.cd_wr      (cd_wr),
		.ioctl_dout (ioctl_dout),
		.cd_byte    (cd_byte),
		.cd_byte_wr (cd_byte_wr),
		.cd_dm      (cd_dm),
		.busy       (cd_busy)
	);

endmodule

// File: rtl/rom_writer.sv
`timescale 1ns/1ps

module rom_writer import loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_start,
	input  logic                   cart_wr,
	input  logic                   sgx_sel,
	input  logic [host_data_w-1:0] ioctl_dout,
	input  logic                   swap_en,
	input  logic                   mem_wr_ack,
	output logic                   mem_wr_req,
	output logic [mem_addr_w-1:0]  mem_wr_addr,
	output logic [host_data_w-1:0] mem_wr_data,
	output logic                   word_done,
	output logic [1:0]             rom_populous,
	output logic                   rom_sgx
);

	logic [host_data_w-1:0] wr_data;
	logic                   pending;
	logic                   in_flight;
	logic                   sig_block;
	logic                   sig_bad;

	////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////

	// Optional bit reversal inside each byte
	always_comb begin
		wr_data = ioctl_dout;
		if (swap_en) begin
			for (int i = 0; i < 8; i++) begin
				wr_data[i]     = ioctl_dout[7 - i];
				wr_data[8 + i] = ioctl_dout[15 - i];
			end
		end
	end

	// Word stays on the memory bus until acknowledged
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			mem_wr_data <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Signature compare
	////////////////////////////////////////////////////////////

	assign sig_block = (mem_wr_addr[mem_addr_w-1:4] == pop_sig_base_a) ||
	                   (mem_wr_addr[mem_addr_w-1:4] == pop_sig_base_b);

	always_comb begin
		case (mem_wr_addr[3:0])
			pop_sig_off0: sig_bad = (wr_data != pop_sig_word0);
			pop_sig_off1: sig_bad = (wr_data != pop_sig_word1);
			pop_sig_off2: sig_bad = (wr_data != pop_sig_word2);
			pop_sig_off3: sig_bad = (wr_data != pop_sig_word3);
			default:      sig_bad = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Request toggle and address
	////////////////////////////////////////////////////////////

	assign pending = (mem_wr_req != mem_wr_ack);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_wr_req   <= 1'b0;
			mem_wr_addr  <= '0;
			in_flight    <= 1'b0;
			word_done    <= 1'b0;
			rom_populous <= 2'b00;
			rom_sgx      <= 1'b0;
		end else begin
			word_done <= 1'b0;
			if (cart_start) begin
				mem_wr_addr  <= '0;
				rom_populous <= 2'b11;
				rom_sgx      <= sgx_sel;
			end else if (cart_wr) begin
				mem_wr_req <= ~mem_wr_req;
				in_flight  <= 1'b1;
				// Address bit 13 tells the two blocks apart
				if (sig_block && sig_bad) begin
					rom_populous[mem_wr_addr[13]] <= 1'b0;
				end
			end else if (in_flight && !pending) begin
				in_flight   <= 1'b0;
				word_done   <= 1'b1;
				mem_wr_addr <= mem_wr_addr + 2'd2;
			end
		end
	end

	// Relies on the host wait to hold the next word back
	assert property (@(posedge clk_sys) disable iff (reset) pending |=> $stable(mem_wr_req))
		else $error("mem_wr_req toggled while a write was pending");

endmodule

// File: sim/tb_checks.svh
`ifndef tb_checks_svh
`define tb_checks_svh

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic abort_run(input string why);
	$display("%s", why);
	$display("TESTS FAILED");
	$fatal(1, "simulation stopped at %0t", $time);
endtask

task automatic check_mem_write(
	input logic [mem_addr_w-1:0]  got_addr,
	input logic [host_data_w-1:0] got_data,
	input logic [mem_addr_w-1:0]  exp_addr,
	input logic [host_data_w-1:0] exp_data
);
	if (got_addr !== exp_addr) begin
		abort_run($sformatf("error mem_wr_addr: got %h expected %h", got_addr, exp_addr));
	end else if (got_data !== exp_data) begin
		abort_run($sformatf("error mem_wr_data at %h: got %h expected %h",
			exp_addr, got_data, exp_data));
	end
endtask

task automatic check_code(input string name, input cheat_code_t got, input cheat_code_t exp);
	if (got !== exp) begin
		abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_flags(input string name, input logic [1:0] got, input logic [1:0] exp);
	if (got !== exp) begin
		abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
	end
endtask

////////////////////////////////////////////////////////////
// Host and memory helpers
////////////////////////////////////////////////////////////

// Entered and left 1 ns after a rising edge
task automatic host_write(input logic [host_addr_w-1:0] addr, input logic [host_data_w-1:0] data);
	ioctl_addr = addr;
	ioctl_dout = data;
	ioctl_wr   = 1'b1;
	@(posedge clk_sys);
	#1;
	ioctl_wr = 1'b0;
endtask

// Idle until ioctl_wait is low, then one spare cycle
task automatic wait_host_ready();
	while (ioctl_wait) begin
		@(posedge clk_sys);
		#1;
	end
	@(posedge clk_sys);
	#1;
endtask

task automatic begin_download(input logic [host_idx_w-1:0] index);
	ioctl_index    = index;
	ioctl_download = 1'b1;
	// Start pulse is registered, first word after it
	repeat (3) @(posedge clk_sys);
	#1;
endtask

task automatic end_download();
	ioctl_download = 1'b0;
	@(posedge clk_sys);
	#1;
endtask

task automatic cart_word(
	input logic [host_addr_w-1:0] addr,
	input logic [host_data_w-1:0] data,
	input logic [host_data_w-1:0] mem_data
);
	int acks_before;
	acks_before = mem_acks;
	mem_exp_addr.push_back(addr[mem_addr_w-1:0]);
	mem_exp_data.push_back(mem_data);
	host_write(addr, data);
	check_bit("ioctl_wait", ioctl_wait, 1'b1);
	while (ioctl_wait) begin
		@(posedge clk_sys);
		#1;
		// Wait may only drop once memory has answered
		if (!ioctl_wait && (mem_acks != acks_before + 1)) begin
			abort_run("ioctl_wait fell before memory acknowledged the word");
		end
	end
	@(posedge clk_sys);
	#1;
endtask

task automatic serve_mem_write();
	logic [mem_addr_w-1:0]  exp_addr;
	logic [host_data_w-1:0] exp_data;
	int                     delay;
	if (mem_exp_addr.size() == 0) begin
		abort_run("memory write request with no host word behind it");
	end else begin
		exp_addr = mem_exp_addr.pop_front();
		exp_data = mem_exp_data.pop_front();
		check_mem_write(mem_wr_addr, mem_wr_data, exp_addr, exp_data);
		delay = 1 + int'(lfsr_bits(3));
		repeat (delay) @(posedge clk_sys);
		#1;
		mem_wr_ack = ~mem_wr_ack;
		mem_acks++;
	end
endtask

`endif

// File: sim/tb_loader_top.sv
`timescale 1ns/1ps

module tb_loader_top import loader_pkg::*; ();

	localparam int cart_words  = 16;
	// Long enough to cover signature block A, the higher of the two
	localparam int pop_words   = (int'(pop_sig_base_a) * 16 + 14) / 2 + 1;
	localparam int cheat_words = 8;
	localparam int cd_len      = 13;
	localparam int cd_words    = 1 + (cd_len + 1) / 2;
	localparam int total_words = 2 * cart_words + 2 * pop_words + cheat_words + cd_words;
	localparam int timeout_cycles = total_words * 12 + 200;

	logic                   clk_sys;
	logic                   reset;
	logic                   ioctl_download;
	logic [host_idx_w-1:0]  ioctl_index;
	logic                   ioctl_wr;
	logic [host_addr_w-1:0] ioctl_addr;
	logic [host_data_w-1:0] ioctl_dout;
	logic                   ioctl_wait;
	logic                   swap_en;
	logic                   mem_wr_req;
	logic                   mem_wr_ack;
	logic [mem_addr_w-1:0]  mem_wr_addr;
	logic [host_data_w-1:0] mem_wr_data;
	logic [1:0]             rom_populous;
	logic                   rom_sgx;
	cheat_code_t            gg_code;
	logic                   gg_code_valid;
	logic [7:0]             cd_byte;
	logic                   cd_byte_wr;
	logic                   cd_dm;

	logic [15:0]            lfsr_state = 16'd40;
	logic [mem_addr_w-1:0]  mem_exp_addr[$];
	logic [host_data_w-1:0] mem_exp_data[$];
	logic [7:0]             cd_seen[$];
	int                     mem_acks;
	int                     cycle_count;

	loader_top DUT (.*);

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [15:0] lfsr_bits(input int count);
		logic [15:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < count; i++) begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			val        = {val[14:0], fb};
		end
		return val;
	endfunction

	// Bit order reversed inside each byte, byte order kept
	function automatic logic [15:0] mirror_bytes(input logic [15:0] w);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[i] = w[i ^ 7];
		end
		return r;
	endfunction

	// Signature word expected at an address, if any
	function automatic logic sig_slot(input logic [mem_addr_w-1:0] a, output logic [15:0] w);
		logic hit;
		hit = (a[mem_addr_w-1:4] == pop_sig_base_a) || (a[mem_addr_w-1:4] == pop_sig_base_b);
		w   = '0;
		case (a[3:0])
			4'd6:    w = pop_sig_word0;
			4'd8:    w = pop_sig_word1;
			4'd10:   w = pop_sig_word2;
			4'd12:   w = pop_sig_word3;
			default: hit = 1'b0;
		endcase
		return hit;
	endfunction

	`include "tb_checks.svh"

	////////////////////////////////////////////////////////////
	// Clock, watchdog, memory and CD byte monitor
	////////////////////////////////////////////////////////////

	initial begin
		clk_sys = 1'b0;
		forever begin
			#5 clk_sys = ~clk_sys;
		end
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk_sys);
			cycle_count++;
			if (cycle_count >= timeout_cycles) begin
				abort_run($sformatf("timeout, run did not finish in %0d cycles", cycle_count));
			end
		end
	end

	initial begin
		mem_wr_ack = 1'b0;
		mem_acks   = 0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (!reset && (mem_wr_req !== mem_wr_ack)) begin
				serve_mem_write();
			end
		end
	end

	initial begin
		forever begin
			@(posedge clk_sys);
			#1;
			if (cd_byte_wr === 1'b1) begin
				cd_seen.push_back(cd_byte);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_cart(input logic [host_idx_w-1:0] index, input logic swap);
		logic [host_data_w-1:0] data;
		swap_en = swap;
		begin_download(index);
		for (int n = 0; n < cart_words; n++) begin
			data = lfsr_bits(16);
			cart_word(host_addr_w'(2 * n), data, swap ? mirror_bytes(data) : data);
		end
		end_download();
		check_bit("rom_sgx", rom_sgx, index[0]);
	endtask

	task automatic test_populous(input logic corrupt_a);
		logic [mem_addr_w-1:0]  addr;
		logic [host_data_w-1:0] data;
		logic [host_data_w-1:0] sig;
		logic                   hit;
		logic [1:0]             exp_flags;
		swap_en   = 1'b0;
		exp_flags = 2'b11;
		begin_download(8'd0);
		for (int n = 0; n < pop_words; n++) begin
			addr = mem_addr_w'(2 * n);
			data = lfsr_bits(16);
			hit  = sig_slot(addr, sig);
			if (hit) begin
				data = sig;
				// One bad word in block A
				if (corrupt_a && addr[3:0] == 4'd8 && addr[mem_addr_w-1:4] == pop_sig_base_a) begin
					data = ~sig;
				end
				if (data != sig) begin
					exp_flags[addr[13]] = 1'b0;
				end
			end
			cart_word(host_addr_w'(addr), data, data);
		end
		end_download();
		check_flags("rom_populous", rom_populous, exp_flags);
	endtask

	task automatic test_cheat();
		logic [host_data_w-1:0] words[cheat_words];
		cheat_code_t            exp;
		begin_download(idx_cheat);
		for (int n = 0; n < cheat_words; n++) begin
			words[n] = lfsr_bits(16);
			host_write(host_addr_w'(2 * n), words[n]);
			check_bit("gg_code_valid", gg_code_valid, n == cheat_words - 1);
			@(posedge clk_sys);
			#1;
		end
		check_bit("gg_code_valid", gg_code_valid, 1'b0);
		end_download();
		exp.fields.flags   = {words[1], words[0]};
		exp.fields.address = {words[3], words[2]};
		exp.fields.compare = {words[5], words[4]};
		exp.fields.replace = {words[7], words[6]};
		check_code("gg_code", gg_code, exp);
	endtask

	task automatic test_cd();
		logic [host_data_w-1:0] data;
		logic [7:0]             exp_bytes[$];
		cd_seen.delete();
		begin_download(idx_cd_data);
		host_write('0, {1'b1, 15'(cd_len)});
		wait_host_ready();
		for (int n = 1; n < cd_words; n++) begin
			data = lfsr_bits(16);
			exp_bytes.push_back(data[7:0]);
			exp_bytes.push_back(data[15:8]);
			host_write(host_addr_w'(2 * n), data);
			wait_host_ready();
		end
		end_download();
		check_bit("cd_dm", cd_dm, 1'b1);
		if (cd_seen.size() != cd_len) begin
			abort_run($sformatf("CD stream gave %0d byte strobes instead of %0d",
				cd_seen.size(), cd_len));
		end else begin
			for (int i = 0; i < cd_len; i++) begin
				check_byte("cd_byte", cd_seen[i], exp_bytes[i]);
			end
		end
	endtask

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		swap_en        = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("gg_code_valid", gg_code_valid, 1'b0);
		check_bit("cd_byte_wr", cd_byte_wr, 1'b0);
		@(posedge clk_sys);
		#1;
		test_cart(8'd0, 1'b0);
		test_cart(8'd1, 1'b1);
		test_populous(1'b0);
		test_populous(1'b1);
		test_cheat();
		test_cd();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+sim
rtl/loader_pkg.sv
rtl/download_ctrl.sv
rtl/rom_writer.sv
rtl/cheat_loader.sv
rtl/cd_sector_streamer.sv
rtl/loader_top.sv
sim/tb_loader_top.sv
